// ==== source/vmpeg_defines.svh ====
`ifndef VMPEG_DEFINES_SVH
`define VMPEG_DEFINES_SVH

// FMV register word addresses, address[15:1]
`define VMPEG_ADDR_TIMECD_HI 15'h202c
`define VMPEG_ADDR_TIMECD_LO 15'h202d
`define VMPEG_ADDR_TMPREF    15'h202e
`define VMPEG_ADDR_STS       15'h202f
`define VMPEG_ADDR_IER       15'h2030
`define VMPEG_ADDR_ISR       15'h2031
`define VMPEG_ADDR_TCNT      15'h2032
`define VMPEG_ADDR_TRLD      15'h2057
`define VMPEG_ADDR_SYSCMD    15'h2060
`define VMPEG_ADDR_IVEC      15'h206e
`define VMPEG_ADDR_XFER      15'h206f

// STS always reports room for more data
`define VMPEG_STS_VALUE 16'h2000

// SYSCMD value that starts a DMA transfer
`define VMPEG_SYSCMD_DMA 16'h8000

// Header FIFO geometry
`define VMPEG_FIFO_DEPTH 64
`define VMPEG_FIFO_AW    6

// Timer base, about 45 kHz from the system clock
`define VMPEG_TICK_DIVIDER    667
`define VMPEG_TIMER_FRAC      3
`define VMPEG_TIMER_RESET_CMP 55  // Roughly a 10 ms period

`endif

// ==== source/fmv_bus_pkg.sv ====
`default_nettype none

`include "vmpeg_defines.svh"

package fmv_bus_pkg;

    // FMV interrupt status and enable layout
    typedef struct packed {
        logic erdv;
        logic erdd;
        logic vcup;
        logic pai;    // Pause
        logic vsync;  // Vertical sync seen
        logic eii;    // End of ISO stream
        logic esi;    // End of sequence
        logic tim;    // Periodic timer
        logic dcl;
        logic ovf;    // Overflow
        logic ndat;
        logic rfb;
        logic eod;    // End of data
        logic pic;    // Picture presented
        logic gop;    // GOP presented
        logic seq;    // Sequence header presented
    } interrupt_flags_t;

    typedef enum logic [14:0] {
        reg_timecd_hi = `VMPEG_ADDR_TIMECD_HI,
        reg_timecd_lo = `VMPEG_ADDR_TIMECD_LO,
        reg_tmpref    = `VMPEG_ADDR_TMPREF,
        reg_sts       = `VMPEG_ADDR_STS,
        reg_ier       = `VMPEG_ADDR_IER,
        reg_isr       = `VMPEG_ADDR_ISR,
        reg_tcnt      = `VMPEG_ADDR_TCNT,
        reg_trld      = `VMPEG_ADDR_TRLD,
        reg_syscmd    = `VMPEG_ADDR_SYSCMD,
        reg_ivec      = `VMPEG_ADDR_IVEC,
        reg_xfer      = `VMPEG_ADDR_XFER
    } fmv_reg_t;

endpackage

`default_nettype wire

// ==== source/mpeg_stream_pkg.sv ====
`default_nettype none

package mpeg_stream_pkg;

    // One summary per picture, as queued for presentation
    typedef struct packed {
        logic [15:0] tmpref;    // Temporal reference times four
        logic [31:0] timecode;  // GOP time code, bits 27:16 used
        logic        seq;
        logic        gop;
        logic        pic;
    } video_header_t;

    // Byte-wise start code walker
    typedef enum logic [3:0] {
        st_idle,
        st_zero1,
        st_zero2,
        st_code,    // 00 00 01 seen, next byte is the code
        st_gop0,
        st_gop1,
        st_gop2,
        st_gop3,
        st_pic0,
        st_pic1,
        st_pic2,
        st_pic3,
        st_slice,
        st_seqhdr
    } parser_state_t;

endpackage

`default_nettype wire

// ==== source/mpeg_header_parser.sv ====
`timescale 1ns/100ps
`default_nettype none

module mpeg_header_parser
    import mpeg_stream_pkg::*;
(
    input  wire           clk,
    input  wire           reset,
    input  wire    [15:0] din,
    input  wire           word_valid,
    output video_header_t entry,
    output logic          entry_write
);

    parser_state_t state;
    logic          byte_pending;   // Low byte waits one cycle
    logic [7:0]    low_byte;
    logic [9:0]    tref;           // Temporal reference being assembled
    logic [9:0]    tref_expected;
    logic [9:0]    tref_q;
    logic [11:0]   timecode_q;     // Maps to timecode[27:16]
    logic          seq_flag;
    logic          gop_flag;
    logic          pic_flag;

    // A pending low byte is handled before the next high byte
    wire [7:0] cur_byte   = byte_pending ? low_byte : din[15:8];
    wire       byte_valid = byte_pending || word_valid;

    assign entry = '{
        tmpref:   {4'b0, tref_q, 2'b0},
        timecode: {4'b0, timecode_q, 16'b0},
        seq:      seq_flag,
        gop:      gop_flag,
        pic:      pic_flag
    };

    always_ff @(posedge clk) begin
        if (word_valid)
            low_byte <= din[7:0];
        if (byte_valid) begin
            case (state)
                st_gop1: timecode_q[11:9] <= cur_byte[2:0];  // Seconds
                st_gop2: timecode_q[8:1] <= cur_byte;
                st_gop3: timecode_q[0] <= cur_byte[7];
                st_pic0: tref[9:2] <= cur_byte;
                st_pic1: tref[1:0] <= cur_byte[7:6];
                st_pic2: if (tref == tref_expected) tref_q <= tref;
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state         <= st_idle;
            byte_pending  <= 1'b0;
            entry_write   <= 1'b0;
            seq_flag      <= 1'b0;
            gop_flag      <= 1'b0;
            pic_flag      <= 1'b0;
            tref_expected <= '0;
        end else begin
            byte_pending <= word_valid;
            entry_write  <= 1'b0;

            // Flags of a written entry start over, later sets still win
            if (entry_write) begin
                seq_flag <= 1'b0;
                gop_flag <= 1'b0;
                pic_flag <= 1'b0;
            end

            if (byte_valid) begin
                case (state)
                    st_idle:  state <= (cur_byte == 8'h00) ? st_zero1 : st_idle;
                    st_zero1: state <= (cur_byte == 8'h00) ? st_zero2 : st_idle;
                    st_zero2: begin
                        if (cur_byte == 8'h01)
                            state <= st_code;
                        else if (cur_byte != 8'h00)
                            state <= st_idle;  // Extra zeros keep waiting
                    end
                    st_code: begin
                        case (cur_byte)
                            8'hb3:   state <= st_seqhdr;
                            8'hb8:   state <= st_gop0;
                            8'h00:   state <= st_pic0;
                            8'h01:   state <= st_slice;
                            default: state <= st_idle;
                        endcase
                    end
                    st_seqhdr: begin
                        state    <= st_idle;
                        seq_flag <= 1'b1;
                    end
                    st_gop0: state <= st_gop1;
                    st_gop1: state <= st_gop2;
                    st_gop2: state <= st_gop3;
                    st_gop3: begin
                        state         <= st_idle;
                        gop_flag      <= 1'b1;
                        tref_expected <= '0;  // New GOP restarts numbering
                    end
                    st_pic0: state <= st_pic1;
                    st_pic1: state <= st_pic2;
                    st_pic2: begin
                        state <= st_pic3;
                        if (tref == tref_expected)
                            tref_expected <= tref_expected + 10'd1;
                    end
                    st_pic3: begin
                        state       <= st_idle;
                        pic_flag    <= 1'b1;
                        entry_write <= 1'b1;
                    end
                    default: state <= st_idle;  // Slice data is skipped
                endcase
            end
        end
    end

endmodule

`default_nettype wire

// ==== source/video_header_fifo.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "vmpeg_defines.svh"

module video_header_fifo
    import mpeg_stream_pkg::*;
(
    input  wire           clk,
    input  wire           reset,
    input  video_header_t in_entry,
    input  wire           write,
    output video_header_t out_entry,
    output logic          out_valid,
    input  wire           pop
);

    video_header_t              mem [`VMPEG_FIFO_DEPTH];
    logic [`VMPEG_FIFO_AW-1:0] wr_idx;
    logic [`VMPEG_FIFO_AW-1:0] rd_idx_q;
    logic [`VMPEG_FIFO_AW-1:0] rd_idx_d;
    logic [`VMPEG_FIFO_AW:0]   count;
    logic                       collide_q;  // Read address was being written

    wire full     = count[`VMPEG_FIFO_AW];
    wire write_ok = write && !full;        // Full FIFO drops the entry
    wire pop_ok   = pop && (count != '0);

    assign rd_idx_d  = pop_ok ? rd_idx_q + 1'b1 : rd_idx_q;
    assign out_valid = (count != '0) && !collide_q;

    always_ff @(posedge clk) begin
        if (write_ok)
            mem[wr_idx] <= in_entry;
        out_entry <= mem[rd_idx_d];  // Stale when read and write hit one slot
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_idx    <= '0;
            rd_idx_q  <= '0;
            count     <= '0;
            collide_q <= 1'b0;
        end else begin
            if (write_ok)
                wr_idx <= wr_idx + 1'b1;
            if (write_ok && !pop_ok)
                count <= count + 1'b1;
            else if (pop_ok && !write_ok)
                count <= count - 1'b1;
            rd_idx_q  <= rd_idx_d;
            collide_q <= write_ok && (wr_idx == rd_idx_d);
        end
    end

endmodule

`default_nettype wire

// ==== source/frame_presenter.sv ====
`timescale 1ns/100ps
`default_nettype none

module frame_presenter
    import fmv_bus_pkg::*;
    import mpeg_stream_pkg::*;
(
    input  wire           clk,
    input  wire           reset,
    input  wire           vsync,
    input  video_header_t fifo_entry,
    input  wire           fifo_valid,
    output logic          pop,
    output logic          vsync_event,
    output logic          seq_event,
    output logic          gop_event,
    output logic          pic_event,
    output logic   [15:0] presented_tmpref,
    output logic   [31:0] presented_timecode
);

    logic             vsync_q;
    logic             toggle;  // Set between the two fields of a frame
    interrupt_flags_t events;

    wire vsync_rise = vsync && !vsync_q;
    wire present    = vsync_rise && toggle && fifo_valid;

    assign vsync_event = events.vsync;
    assign seq_event   = events.seq;
    assign gop_event   = events.gop;
    assign pic_event   = events.pic;

    always_ff @(posedge clk) begin
        if (reset) begin
            vsync_q <= 1'b0;
            toggle  <= 1'b0;
            pop     <= 1'b0;
            events  <= '0;
        end else begin
            vsync_q <= vsync;
            pop     <= present;
            events  <= '0;
            if (vsync_rise) begin
                events.vsync <= 1'b1;
                toggle       <= !toggle;
            end
            if (present) begin
                events.seq <= fifo_entry.seq;
                events.gop <= fifo_entry.gop;
                events.pic <= fifo_entry.pic;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (present) begin
            presented_tmpref   <= fifo_entry.tmpref;
            presented_timecode <= fifo_entry.timecode;
        end
    end

endmodule

`default_nettype wire

// ==== source/fmv_timer.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "vmpeg_defines.svh"

module fmv_timer (
    input  wire        clk,
    input  wire        reset,
    input  wire [15:0] timer_cmp,
    input  wire        timer_reload,
    output logic       timer_event
);

    localparam int div_w = $clog2(`VMPEG_TICK_DIVIDER);

    logic [div_w-1:0]               div_cnt;
    logic [15+`VMPEG_TIMER_FRAC:0] tick_cnt;  // Integer part above the fraction

    wire div_done = div_cnt == div_w'(`VMPEG_TICK_DIVIDER - 1);
    wire cmp_hit  = tick_cnt[15+`VMPEG_TIMER_FRAC:`VMPEG_TIMER_FRAC] == timer_cmp;

    always_ff @(posedge clk) begin
        if (reset) begin
            div_cnt     <= '0;
            tick_cnt    <= '0;
            timer_event <= 1'b0;
        end else begin
            timer_event <= div_done && cmp_hit;
            if (div_done) begin
                div_cnt  <= '0;
                tick_cnt <= cmp_hit ? '0 : tick_cnt + 1'b1;
            end else begin
                div_cnt <= div_cnt + 1'b1;
            end
            if (timer_reload)
                tick_cnt <= '0;  // Period restarts from the host
        end
    end

endmodule

`default_nettype wire

// ==== source/fmv_host_registers.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "vmpeg_defines.svh"

module fmv_host_registers
    import fmv_bus_pkg::*;
(
    input  wire        clk,
    input  wire        reset,
    input  wire [23:1] address,
    input  wire [15:0] din,
    input  wire        uds,
    input  wire        lds,
    input  wire        write_strobe,
    input  wire        cs,
    input  wire        intack,
    output logic [15:0] dout,
    output logic       bus_ack,
    output logic       intreq,
    input  wire        ack,
    input  wire        dtc,
    input  wire        done_in,
    output logic       req,
    output logic       rdy,
    output logic       word_valid,
    input  wire        vsync_event,
    input  wire        seq_event,
    input  wire        gop_event,
    input  wire        pic_event,
    input  wire        timer_event,
    input  wire [15:0] presented_tmpref,
    input  wire [31:0] presented_timecode,
    output logic [15:0] timer_cmp,
    output logic       timer_reload
);

    interrupt_flags_t isr;
    interrupt_flags_t ier;
    logic [15:0]      ivec;
    logic [15:0]      tcnt;
    logic             dma_active;

    fmv_reg_t reg_addr;
    assign reg_addr = fmv_reg_t'(address[15:1]);

    wire access   = cs && (uds || lds);
    wire accepted = access && bus_ack;  // Second cycle of the access
    wire wr_acc   = accepted && write_strobe;
    wire rd_acc   = accepted && !write_strobe;

    assign intreq       = (isr & ier) != '0;
    assign req          = dma_active;
    assign rdy          = dma_active;
    assign timer_cmp    = tcnt;
    assign timer_reload = wr_acc && (reg_addr == reg_trld);

    // DMA words and XFER writes feed the same stream
    assign word_valid = (ack && dtc) || (wr_acc && (reg_addr == reg_xfer));

    always_comb begin
        dout = '0;
        case (reg_addr)
            reg_timecd_hi: dout = presented_timecode[31:16];
            reg_timecd_lo: dout = presented_timecode[15:0];
            reg_tmpref:    dout = presented_tmpref;
            reg_sts:       dout = `VMPEG_STS_VALUE;
            reg_ier:       dout = ier;
            reg_isr:       dout = isr;
            reg_tcnt:      dout = tcnt;
            reg_ivec:      dout = ivec;
            default:       ;
        endcase
        if (intack)
            dout = {ivec[10:3], ivec[10:3]};  // Vector fetch cycle
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            bus_ack    <= 1'b0;
            isr        <= '0;
            ier        <= '0;
            ivec       <= '0;
            tcnt       <= 16'(`VMPEG_TIMER_RESET_CMP);
            dma_active <= 1'b0;
        end else begin
            bus_ack <= access && !bus_ack;

            if (vsync_event) isr.vsync <= 1'b1;
            if (seq_event)   isr.seq   <= 1'b1;
            if (gop_event)   isr.gop   <= 1'b1;
            if (pic_event)   isr.pic   <= 1'b1;
            if (timer_event) isr.tim   <= 1'b1;

            // Reading ISR acknowledges everything
            if (rd_acc && (reg_addr == reg_isr))
                isr <= '0;

            if (done_in && ack)
                dma_active <= 1'b0;

            if (wr_acc) begin
                case (reg_addr)
                    reg_ier:  ier  <= interrupt_flags_t'(din);
                    reg_tcnt: tcnt <= din;
                    reg_ivec: ivec <= din;
                    reg_syscmd: begin
                        if (din == `VMPEG_SYSCMD_DMA)
                            dma_active <= 1'b1;
                    end
                    default: ;
                endcase
            end
        end
    end

endmodule

`default_nettype wire

// ==== source/vmpeg.sv ====
`timescale 1ns/100ps
`default_nettype none

module vmpeg
    import mpeg_stream_pkg::*;
(
    input  wire        clk,
    input  wire        reset,
    input  wire [23:1] address,
    input  wire [15:0] din,
    output wire [15:0] dout,
    input  wire        uds,
    input  wire        lds,
    input  wire        write_strobe,
    input  wire        cs,
    output wire        bus_ack,
    output wire        intreq,
    input  wire        intack,
    output wire        req,
    input  wire        ack,
    output wire        rdy,
    input  wire        dtc,
    input  wire        done_in,
    input  wire        vsync
);

    wire           word_valid;
    video_header_t entry;
    wire           entry_write;
    video_header_t fifo_entry;
    wire           fifo_valid;
    wire           pop;
    wire           vsync_event;
    wire           seq_event;
    wire           gop_event;
    wire           pic_event;
    wire [15:0]    presented_tmpref;
    wire [31:0]    presented_timecode;
    wire [15:0]    timer_cmp;
    wire           timer_reload;
    wire           timer_event;

    fmv_host_registers u_regs (
        .clk, .reset, .address, .din, .uds, .lds, .write_strobe, .cs, .intack,
        .dout, .bus_ack, .intreq, .ack, .dtc, .done_in, .req, .rdy, .word_valid,
        .vsync_event, .seq_event, .gop_event, .pic_event, .timer_event,
        .presented_tmpref, .presented_timecode, .timer_cmp, .timer_reload
    );

    mpeg_header_parser u_parser (
        .clk, .reset, .din, .word_valid, .entry, .entry_write
    );

    video_header_fifo u_fifo (
        .clk,
        .reset,
        .in_entry  (entry),
        .write     (entry_write),
        .out_entry (fifo_entry),
        .out_valid (fifo_valid),
        .pop
    );

    frame_presenter u_presenter (
        .clk, .reset, .vsync, .fifo_entry, .fifo_valid, .pop,
        .vsync_event, .seq_event, .gop_event, .pic_event,
        .presented_tmpref, .presented_timecode
    );

    fmv_timer u_timer (
        .clk, .reset, .timer_cmp, .timer_reload, .timer_event
    );

endmodule

`default_nettype wire

// ==== test/vmpeg_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "vmpeg_defines.svh"

module vmpeg_tb;

    localparam int timer_wait  = 2 * `VMPEG_TICK_DIVIDER * 8;
    localparam int cycle_limit = timer_wait + 3000;  // Bus, stream and vsync traffic on top

    localparam logic [15:0] ivec_value = 16'h0758;
    localparam logic [7:0]  gop_b0 = 8'h08;
    localparam logic [7:0]  gop_b1 = 8'h3d;
    localparam logic [7:0]  gop_b2 = 8'h9c;
    localparam logic [7:0]  gop_b3 = 8'hc0;

    logic        clk;
    logic        reset;
    logic [23:1] address;
    logic [15:0] din;
    logic        uds;
    logic        lds;
    logic        write_strobe;
    logic        cs;
    logic        intack;
    logic        ack;
    logic        dtc;
    logic        done_in;
    logic        vsync;
    wire  [15:0] dout;
    wire         bus_ack;
    wire         intreq;
    wire         req;
    wire         rdy;

    int          errors;
    int          checks;
    int          cycle_count;
    logic [15:0] lfsr_state;
    logic        intreq_at_read;  // intreq seen with the read data
    logic [15:0] ier_written;
    logic [7:0]  stream_q[$];
    logic [15:0] tmpref_q[$];     // Expected TMPREF per queued picture
    logic [15:0] timecd_q[$];
    logic [15:0] tmpref_model;
    logic [9:0]  tref_expected_model;
    logic [15:0] timecd_model;

    wire cpu_access = cs && (uds || lds);

    vmpeg u_vmpeg (
        .clk, .reset, .address, .din, .dout, .uds, .lds, .write_strobe, .cs,
        .bus_ack, .intreq, .intack, .req, .ack, .rdy, .dtc, .done_in, .vsync
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    initial begin
        cycle_count = 0;
        while (cycle_count < cycle_limit) begin
            @(posedge clk);
            cycle_count++;
        end
        errors++;
        $display("Run stopped after %0d cycles without reaching the end", cycle_limit);
        $display("Checks: %0d  Errors: %0d", checks, errors);
        $display("Some tests failed");
        $finish;
    end

    // bus_ack only rises out of an access and drops again right away
    assert property (@(posedge clk) disable iff (reset) bus_ack |-> $past(cpu_access))
        else begin
            errors++;
            $display("bus_ack high at %0t without an access the cycle before", $time);
        end
    assert property (@(posedge clk) disable iff (reset) bus_ack |=> !bus_ack)
        else begin
            errors++;
            $display("bus_ack stayed high for two cycles at %0t", $time);
        end

    // 16-bit Galois LFSR with taps 16 14 13 11
    function automatic logic [15:0] lfsr_next(input logic [15:0] state);
        if (state[0])
            return (state >> 1) ^ 16'hb400;
        return state >> 1;
    endfunction

    task automatic compare_value(input string name, input logic [15:0] got,
                                 input logic [15:0] expected);
        checks++;
        assert (got === expected) else begin
            errors++;
            $display("MISMATCH at %0t: %s got %h expected %h", $time, name, got, expected);
        end
    endtask

    task automatic compare_bit(input string name, input logic got, input logic expected);
        checks++;
        assert (got === expected) else begin
            errors++;
            $display("MISMATCH at %0t: %s got %b expected %b", $time, name, got, expected);
        end
    endtask

    task automatic bus_access(input logic [14:0] reg_word, input logic is_write,
                              input logic [15:0] wdata, output logic [15:0] rdata);
        int waited;
        waited = 0;
        @(negedge clk);
        address = {8'h00, reg_word};
        if (is_write)
            din = wdata;
        write_strobe = is_write;
        cs = 1'b1;
        uds = 1'b1;
        lds = 1'b1;
        @(negedge clk);
        while (!bus_ack && waited < 4) begin
            @(negedge clk);
            waited++;
        end
        assert (bus_ack) else begin
            errors++;
            $display("Access to register %h was never acknowledged", reg_word);
        end
        rdata = dout;  // Accepted on the coming rising edge
        intreq_at_read = intreq;
        @(negedge clk);
        cs = 1'b0;
        uds = 1'b0;
        lds = 1'b0;
        write_strobe = 1'b0;
    endtask

    task automatic bus_write(input logic [14:0] reg_word, input logic [15:0] data);
        logic [15:0] ignored;
        bus_access(reg_word, 1'b1, data, ignored);
    endtask

    task automatic bus_read(input logic [14:0] reg_word, output logic [15:0] data);
        bus_access(reg_word, 1'b0, 16'h0000, data);
    endtask

    task automatic check_isr(input logic [15:0] expected);
        logic [15:0] value;
        bus_read(`VMPEG_ADDR_ISR, value);
        compare_value("ISR", value, expected);
        compare_bit("intreq", intreq_at_read, |(value & ier_written));
    endtask

    // Bit 7 forced high so filler never opens a start code
    task automatic filler_byte(output logic [7:0] value);
        for (int i = 0; i < 7; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            value[i] = lfsr_state[0];
        end
        value[7] = 1'b1;
    endtask

    task automatic insert_filler(input int count);
        logic [7:0] value;
        repeat (count) begin
            filler_byte(value);
            stream_q.push_back(value);
        end
    endtask

    task automatic start_code(input logic [7:0] code);
        stream_q.push_back(8'h00);
        stream_q.push_back(8'h00);
        stream_q.push_back(8'h01);
        stream_q.push_back(code);
    endtask

    task automatic gop_header();
        start_code(8'hb8);
        stream_q.push_back(gop_b0);
        stream_q.push_back(gop_b1);
        stream_q.push_back(gop_b2);
        stream_q.push_back(gop_b3);
        timecd_model = {4'b0, gop_b1[2:0], gop_b2, gop_b3[7]};  // Timecode bits 31:16
        tref_expected_model = '0;
    endtask

    task automatic picture_header(input logic [9:0] tref);
        start_code(8'h00);
        stream_q.push_back(tref[9:2]);
        stream_q.push_back({tref[1:0], 6'h15});
        stream_q.push_back(8'hff);
        stream_q.push_back(8'hf8);
        // Out of order references leave TMPREF alone
        if (tref == tref_expected_model) begin
            tmpref_model = {4'b0, tref, 2'b00};
            tref_expected_model = tref_expected_model + 10'd1;
        end
        tmpref_q.push_back(tmpref_model);
        timecd_q.push_back(timecd_model);
    endtask

    task automatic dma_word(input logic [15:0] word);
        @(negedge clk);
        din = word;
        ack = 1'b1;
        dtc = 1'b1;
        @(negedge clk);
        ack = 1'b0;
        dtc = 1'b0;
    endtask

    task automatic send_bytes(input logic by_dma);
        logic [7:0]  pad;
        logic [15:0] word;
        if (stream_q.size() % 2 != 0) begin
            filler_byte(pad);
            stream_q.push_back(pad);
        end
        while (stream_q.size() > 0) begin
            word[15:8] = stream_q.pop_front();  // High byte goes first
            word[7:0] = stream_q.pop_front();
            if (by_dma)
                dma_word(word);
            else
                bus_write(`VMPEG_ADDR_XFER, word);
        end
    endtask

    task automatic vsync_pulse();
        @(negedge clk);
        vsync = 1'b1;
        repeat (4) @(negedge clk);
        vsync = 1'b0;
        repeat (4) @(negedge clk);
    endtask

    task automatic present_frame(input logic [15:0] isr_expected, input logic split_fields);
        logic [15:0] value;
        vsync_pulse();
        if (split_fields)
            check_isr(16'h0800);  // First field flags vsync only
        vsync_pulse();
        bus_read(`VMPEG_ADDR_TMPREF, value);
        compare_value("TMPREF", value, tmpref_q.pop_front());
        bus_read(`VMPEG_ADDR_TIMECD_HI, value);
        compare_value("TIMECD_HI", value, timecd_q.pop_front());
        bus_read(`VMPEG_ADDR_TIMECD_LO, value);
        compare_value("TIMECD_LO", value, 16'h0000);
        check_isr(isr_expected);
    endtask

    task automatic wait_for_timer();
        int waited;
        waited = 0;
        checks++;
        while (!intreq && waited < timer_wait) begin
            @(negedge clk);
            waited++;
        end
        assert (intreq) else begin
            errors++;
            $display("Timer interrupt did not arrive within %0d cycles", timer_wait);
        end
    endtask

    initial begin
        logic [15:0] value;
        errors = 0;
        checks = 0;
        lfsr_state = 16'd43;
        ier_written = '0;
        intreq_at_read = 1'b0;
        tmpref_model = '0;
        tref_expected_model = '0;
        timecd_model = '0;
        reset = 1'b1;
        address = '0;
        din = '0;
        uds = 1'b0;
        lds = 1'b0;
        write_strobe = 1'b0;
        cs = 1'b0;
        intack = 1'b0;
        ack = 1'b0;
        dtc = 1'b0;
        done_in = 1'b0;
        vsync = 1'b0;
        repeat (4) @(negedge clk);
        reset = 1'b0;
        @(negedge clk);

        // Reset values and register read back
        compare_bit("req", req, 1'b0);
        compare_bit("rdy", rdy, 1'b0);
        compare_bit("intreq", intreq, 1'b0);
        compare_bit("bus_ack", bus_ack, 1'b0);
        bus_read(`VMPEG_ADDR_TCNT, value);
        compare_value("TCNT", value, 16'd55);
        bus_write(`VMPEG_ADDR_IER, 16'h5a5a);
        ier_written = 16'h5a5a;
        bus_read(`VMPEG_ADDR_IER, value);
        compare_value("IER", value, 16'h5a5a);
        bus_write(`VMPEG_ADDR_IVEC, ivec_value);
        bus_read(`VMPEG_ADDR_IVEC, value);
        compare_value("IVEC", value, ivec_value);
        bus_write(`VMPEG_ADDR_TCNT, 16'h1234);  // Keeps the timer quiet for a long while
        bus_read(`VMPEG_ADDR_TCNT, value);
        compare_value("TCNT", value, 16'h1234);
        bus_read(`VMPEG_ADDR_STS, value);
        compare_value("STS", value, 16'h2000);
        bus_write(`VMPEG_ADDR_IER, 16'h0000);
        ier_written = 16'h0000;
        check_isr(16'h0000);

        // Headers over XFER
        insert_filler(3);
        start_code(8'hb3);
        insert_filler(6);
        gop_header();
        insert_filler(2);
        picture_header(10'd0);
        insert_filler(5);
        picture_header(10'd1);
        insert_filler(3);
        send_bytes(1'b0);
        present_frame(16'h0807, 1'b0);
        check_isr(16'h0000);

        // Picture interrupt and vector fetch
        bus_write(`VMPEG_ADDR_IER, 16'h0004);
        ier_written = 16'h0004;
        compare_bit("intreq", intreq, 1'b0);
        present_frame(16'h0804, 1'b1);
        compare_bit("intreq", intreq, 1'b0);
        @(negedge clk);
        intack = 1'b1;
        @(negedge clk);
        compare_value("dout", dout, {ivec_value[10:3], ivec_value[10:3]});
        intack = 1'b0;

        // DMA path
        bus_write(`VMPEG_ADDR_SYSCMD, 16'h8000);
        compare_bit("req", req, 1'b1);
        compare_bit("rdy", rdy, 1'b1);
        insert_filler(4);
        picture_header(10'd2);
        insert_filler(4);
        send_bytes(1'b1);
        present_frame(16'h0804, 1'b0);
        insert_filler(2);
        picture_header(10'd7);
        insert_filler(2);
        send_bytes(1'b1);
        present_frame(16'h0804, 1'b0);
        @(negedge clk);
        done_in = 1'b1;
        ack = 1'b1;
        @(negedge clk);
        done_in = 1'b0;
        ack = 1'b0;
        compare_bit("req", req, 1'b0);
        compare_bit("rdy", rdy, 1'b0);

        // Periodic timer at compare zero
        bus_write(`VMPEG_ADDR_IER, 16'h0100);
        ier_written = 16'h0100;
        bus_write(`VMPEG_ADDR_TCNT, 16'h0000);
        bus_write(`VMPEG_ADDR_TRLD, 16'h0000);
        bus_read(`VMPEG_ADDR_ISR, value);
        wait_for_timer();
        check_isr(16'h0100);

        $display("Checks: %0d  Errors: %0d", checks, errors);
        if (errors == 0)
            $display("All tests passed");
        else
            $display("Some tests failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== all.f ====
+incdir+source
source/fmv_bus_pkg.sv
source/mpeg_stream_pkg.sv
source/mpeg_header_parser.sv
source/video_header_fifo.sv
source/frame_presenter.sv
source/fmv_timer.sv
source/fmv_host_registers.sv
source/vmpeg.sv
test/vmpeg_tb.sv

// ==== Makefile ====
VERILATOR  ?= verilator
FILELIST   ?= all.f
TB_TOP     ?= vmpeg_tb
RTL_TOP    ?= vmpeg
BUILD_DIR  ?= obj_dir
SIM_FLAGS  ?= --binary --assert -j 0
LINT_FLAGS ?= --lint-only -Wall --timing
PASS_TEXT  ?= All tests passed

.PHONY: lint build sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

build:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TB_TOP) --Mdir $(BUILD_DIR)

sim: build
	@out="$$(./$(BUILD_DIR)/V$(TB_TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)
